// ==== dbg.f ====
+incdir+include
source/dbg_pkg.sv
source/dbg_cmd_decode.sv
source/dbg_bus_engine.sv
source/dbg_cpu_ctrl.sv
source/dbg_result_shift.sv
source/dbg_top.sv
verification/dbg_tb.sv

// ==== include/dbg_macros.svh ====
`ifndef DBG_MACROS_SVH
`define DBG_MACROS_SVH

// register and bus sizes.
`define DBG_DR_WIDTH 64
`define DBG_ADDR_WIDTH 16
`define DBG_DATA_WIDTH 32
`define DBG_NB_CORES 2
`define DBG_RESULT_WIDTH 33

// breakpoint, stall and reset flags for each core.
`define DBG_STATUS_WIDTH (3 * `DBG_NB_CORES)

// field positions in the data register.
`define DBG_SEL_BIT 63
`define DBG_MOD_MSB 62
`define DBG_MOD_LSB 58
`define DBG_OP_MSB 62
`define DBG_OP_LSB 59
`define DBG_DATA_MSB 58
`define DBG_DATA_LSB 27
`define DBG_ADDR_MSB 26
`define DBG_ADDR_LSB 11

`endif

// ==== run_dbg.sh ====
#!/bin/sh
# builds the dbg testbench with verilator, runs it and checks its verdict.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/100ps -f dbg.f --top-module dbg_tb -o dbg_sim \
	|| { echo "build failed"; exit 1; }
out=$(./obj_dir/dbg_sim) || { echo "$out"; echo "simulation aborted"; exit 1; }
echo "$out"
echo "$out" | grep -q "Everything OK" && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== source/dbg_bus_engine.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "dbg_macros.svh"

module dbg_bus_engine
	import dbg_pkg::*;
(
	input  logic                          tck_i,
	input  logic                          trstn_i,
	input  logic                          start_i,
	input  dbg_op_e                       op_i,
	input  logic [`DBG_ADDR_WIDTH-1:0]    addr_i,
	input  logic [`DBG_DATA_WIDTH-1:0]    wdata_i,
	output logic                          busy_o,
	output logic                          done_o,
	output logic [`DBG_DATA_WIDTH-1:0]    rdata_o,
	output logic                          bus_stb_o,
	output logic                          bus_we_o,
	output logic [`DBG_ADDR_WIDTH-1:0]    bus_addr_o,
	output logic [`DBG_DATA_WIDTH-1:0]    bus_wdata_o,
	input  logic                          bus_ack_i,
	input  logic [`DBG_DATA_WIDTH-1:0]    bus_rdata_i
);

	bus_state_e                    state_q;
	logic                          stb_q;
	logic                          we_q;
	logic                          done_q;
	logic [`DBG_ADDR_WIDTH-1:0]    addr_q;
	logic [`DBG_DATA_WIDTH-1:0]    wdata_q;
	logic [`DBG_DATA_WIDTH-1:0]    rdata_q;
	logic                          is_bus_op;
	logic                          launch;

	assign is_bus_op = (op_i == OP_BUS_WRITE) || (op_i == OP_BUS_READ);
	assign launch = (state_q == BUS_IDLE) && start_i && is_bus_op; // other opcodes are dropped.

	always_ff @(posedge tck_i or negedge trstn_i) begin
		if (!trstn_i) begin
			state_q <= BUS_IDLE;
			stb_q <= 1'b0;
			we_q <= 1'b0;
			done_q <= 1'b0;
			rdata_q <= '0;
		end else begin
			case (state_q)
				BUS_IDLE: begin
					if (launch) begin
						state_q <= BUS_REQ;
						we_q <= (op_i == OP_BUS_WRITE);
						done_q <= 1'b0;
					end
				end
				BUS_REQ: begin
					// stb goes up one cycle after the request is taken.
					if (!stb_q) begin
						stb_q <= 1'b1;
					end else if (bus_ack_i) begin
						stb_q <= 1'b0;
						state_q <= BUS_WAIT_DONE;
						if (!we_q)
							rdata_q <= bus_rdata_i;
					end
				end
				BUS_WAIT_DONE: begin
					done_q <= 1'b1;
					we_q <= 1'b0;
					state_q <= BUS_IDLE;
				end
				default: state_q <= BUS_IDLE;
			endcase
		end
	end

	// address and data stay put for the whole access.
	always_ff @(posedge tck_i) begin
		if (launch) begin
			addr_q <= addr_i;
			wdata_q <= wdata_i;
		end
	end

	assign busy_o = (state_q != BUS_IDLE);
	assign done_o = done_q;
	assign rdata_o = rdata_q;
	assign bus_stb_o = stb_q;
	assign bus_we_o = we_q;
	assign bus_addr_o = addr_q;
	assign bus_wdata_o = wdata_q;

endmodule

`default_nettype wire

// ==== source/dbg_cmd_decode.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "dbg_macros.svh"

module dbg_cmd_decode
	import dbg_pkg::*;
(
	input  logic                          tck_i,
	input  logic                          trstn_i,
	input  logic                          tdi_i,
	input  logic                          shift_dr_i,
	input  logic                          update_dr_i,
	input  logic                          debug_select_i,
	input  logic                          busy_i,
	output dbg_module_e                   module_o,
	output logic                          bus_start_o,
	output logic                          cpu_start_o,
	output dbg_op_e                       op_o,
	output logic [`DBG_ADDR_WIDTH-1:0]    addr_o,
	output logic [`DBG_DATA_WIDTH-1:0]    wdata_o
);

	logic [`DBG_DR_WIDTH-1:0]      dr_q;
	dbg_module_e                   module_q;
	dbg_op_e                       op_q;
	logic                          bus_start_q;
	logic                          cpu_start_q;
	logic [`DBG_ADDR_WIDTH-1:0]    addr_q;
	logic [`DBG_DATA_WIDTH-1:0]    wdata_q;
	logic                          cmd_valid;
	logic                          cmd_launch;

	// a running access blocks both kinds of command.
	assign cmd_valid = update_dr_i && debug_select_i && !busy_i;
	assign cmd_launch = cmd_valid && !dr_q[`DBG_SEL_BIT];

	// tdi enters at the top, lsb first.
	always_ff @(posedge tck_i or negedge trstn_i) begin
		if (!trstn_i)
			dr_q <= '0;
		else if (shift_dr_i && debug_select_i)
			dr_q <= {tdi_i, dr_q[`DBG_DR_WIDTH-1:1]};
	end

	always_ff @(posedge tck_i or negedge trstn_i) begin
		if (!trstn_i) begin
			module_q <= MOD_BUS;
			op_q <= OP_NOP;
			bus_start_q <= 1'b0;
			cpu_start_q <= 1'b0;
		end else begin
			bus_start_q <= 1'b0; // pulses last one cycle.
			cpu_start_q <= 1'b0;
			if (cmd_valid && dr_q[`DBG_SEL_BIT]) begin
				module_q <= dbg_module_e'(dr_q[`DBG_MOD_MSB:`DBG_MOD_LSB]);
			end else if (cmd_launch) begin
				op_q <= dbg_op_e'(dr_q[`DBG_OP_MSB:`DBG_OP_LSB]);
				bus_start_q <= (module_q == MOD_BUS);
				cpu_start_q <= (module_q == MOD_CPU); // unmapped ids start nothing.
			end
		end
	end

	always_ff @(posedge tck_i) begin
		if (cmd_launch) begin
			addr_q <= dr_q[`DBG_ADDR_MSB:`DBG_ADDR_LSB];
			wdata_q <= dr_q[`DBG_DATA_MSB:`DBG_DATA_LSB];
		end
	end

	assign module_o = module_q;
	assign op_o = op_q;
	assign bus_start_o = bus_start_q;
	assign cpu_start_o = cpu_start_q;
	assign addr_o = addr_q;
	assign wdata_o = wdata_q;

endmodule

`default_nettype wire

// ==== source/dbg_cpu_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "dbg_macros.svh"

module dbg_cpu_ctrl
	import dbg_pkg::*;
(
	input  logic                            tck_i,
	input  logic                            trstn_i,
	input  logic                            start_i,
	input  dbg_op_e                         op_i,
	input  logic [`DBG_DATA_WIDTH-1:0]      wdata_i,
	input  logic [`DBG_NB_CORES-1:0]        cpu_bp_i,
	output logic [`DBG_NB_CORES-1:0]        cpu_stall_o,
	output logic [`DBG_NB_CORES-1:0]        cpu_rst_o,
	output logic [`DBG_STATUS_WIDTH-1:0]    status_o
);

	logic [`DBG_NB_CORES-1:0]    stall_q;
	logic [`DBG_NB_CORES-1:0]    rst_q;
	logic [`DBG_NB_CORES-1:0]    bp_q;
	logic                        cpu_write;

	assign cpu_write = start_i && (op_i == OP_CPU_WRITE);

	always_ff @(posedge tck_i or negedge trstn_i) begin
		if (!trstn_i) begin
			stall_q <= '0;
			rst_q <= '0;
			bp_q <= '0;
		end else if (cpu_write) begin
			stall_q <= wdata_i[`DBG_NB_CORES-1:0] | cpu_bp_i;
			rst_q <= wdata_i[2*`DBG_NB_CORES-1:`DBG_NB_CORES];
			bp_q <= cpu_bp_i; // a breakpoint still held wins over the clear.
		end else begin
			stall_q <= stall_q | cpu_bp_i;
			bp_q <= bp_q | cpu_bp_i;
		end
	end

	assign cpu_stall_o = stall_q;
	assign cpu_rst_o = rst_q;
	assign status_o = {bp_q, stall_q, rst_q};

endmodule

`default_nettype wire

// ==== source/dbg_pkg.sv ====
`default_nettype none

package dbg_pkg;

	// module ids above 1 select nothing.
	typedef enum logic [4:0] {
		MOD_BUS = 5'd0,
		MOD_CPU = 5'd1
	} dbg_module_e;

	// opcodes of a module command.
	typedef enum logic [3:0] {
		OP_NOP        = 4'd0,
		OP_BUS_WRITE  = 4'd1,
		OP_BUS_READ   = 4'd2,
		OP_CPU_WRITE  = 4'd3,
		OP_CPU_STATUS = 4'd4
	} dbg_op_e;

	typedef enum logic [1:0] {
		BUS_IDLE      = 2'd0,
		BUS_REQ       = 2'd1, // stb raised and waiting for ack.
		BUS_WAIT_DONE = 2'd2
	} bus_state_e;

endpackage

`default_nettype wire

// ==== source/dbg_result_shift.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "dbg_macros.svh"

module dbg_result_shift
	import dbg_pkg::*;
(
	input  logic                            tck_i,
	input  logic                            trstn_i,
	input  logic                            capture_dr_i,
	input  logic                            shift_dr_i,
	input  logic                            debug_select_i,
	input  dbg_module_e                     module_i,
	input  logic                            done_i,
	input  logic [`DBG_DATA_WIDTH-1:0]      rdata_i,
	input  logic [`DBG_STATUS_WIDTH-1:0]    status_i,
	output logic                            tdo_o
);

	logic [`DBG_RESULT_WIDTH-1:0]    result_q;
	logic [`DBG_RESULT_WIDTH-1:0]    result_d;

	// the low bit is the bus done flag or a constant 1 for the cpu.
	always_comb begin
		case (module_i)
			MOD_BUS: result_d = {rdata_i, done_i};
			MOD_CPU: result_d = {{(`DBG_DATA_WIDTH-`DBG_STATUS_WIDTH){1'b0}}, status_i, 1'b1};
			default: result_d = '0;
		endcase
	end

	always_ff @(posedge tck_i or negedge trstn_i) begin
		if (!trstn_i)
			result_q <= '0;
		else if (capture_dr_i)
			result_q <= result_d;
		else if (shift_dr_i && debug_select_i)
			result_q <= {1'b0, result_q[`DBG_RESULT_WIDTH-1:1]}; // zeros follow the result.
	end

	assign tdo_o = result_q[0];

endmodule

`default_nettype wire

// ==== source/dbg_top.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "dbg_macros.svh"

module dbg_top
	import dbg_pkg::*;
(
	input  logic                          tck_i,
	input  logic                          trstn_i,
	input  logic                          tdi_i,
	output logic                          tdo_o,
	input  logic                          shift_dr_i,
	input  logic                          update_dr_i,
	input  logic                          capture_dr_i,
	input  logic                          debug_select_i,
	output logic                          bus_stb_o,
	output logic                          bus_we_o,
	output logic [`DBG_ADDR_WIDTH-1:0]    bus_addr_o,
	output logic [`DBG_DATA_WIDTH-1:0]    bus_wdata_o,
	input  logic                          bus_ack_i,
	input  logic [`DBG_DATA_WIDTH-1:0]    bus_rdata_i,
	input  logic [`DBG_NB_CORES-1:0]      cpu_bp_i,
	output logic [`DBG_NB_CORES-1:0]      cpu_stall_o,
	output logic [`DBG_NB_CORES-1:0]      cpu_rst_o
);

	dbg_module_e                     module_sel;
	dbg_op_e                         op;
	logic                            bus_start;
	logic                            cpu_start;
	logic                            bus_busy;
	logic                            bus_done;
	logic [`DBG_ADDR_WIDTH-1:0]      cmd_addr;
	logic [`DBG_DATA_WIDTH-1:0]      cmd_wdata;
	logic [`DBG_DATA_WIDTH-1:0]      bus_rdata;
	logic [`DBG_STATUS_WIDTH-1:0]    cpu_status;

	dbg_cmd_decode i_cmd_decode (
		.tck_i          (tck_i),
		.trstn_i        (trstn_i),
		.tdi_i          (tdi_i),
		.shift_dr_i     (shift_dr_i),
		.update_dr_i    (update_dr_i),
		.debug_select_i (debug_select_i),
		.busy_i         (bus_busy),
		.module_o       (module_sel),
		.bus_start_o    (bus_start),
		.cpu_start_o    (cpu_start),
		.op_o           (op),
		.addr_o         (cmd_addr),
		.wdata_o        (cmd_wdata)
	);

	dbg_bus_engine i_bus_engine (
		.tck_i       (tck_i),
		.trstn_i     (trstn_i),
		.start_i     (bus_start),
		.op_i        (op),
		.addr_i      (cmd_addr),
		.wdata_i     (cmd_wdata),
		.busy_o      (bus_busy),
		.done_o      (bus_done),
		.rdata_o     (bus_rdata),
		.bus_stb_o   (bus_stb_o),
		.bus_we_o    (bus_we_o),
		.bus_addr_o  (bus_addr_o),
		.bus_wdata_o (bus_wdata_o),
		.bus_ack_i   (bus_ack_i),
		.bus_rdata_i (bus_rdata_i)
	);

	dbg_cpu_ctrl i_cpu_ctrl (
		.tck_i       (tck_i),
		.trstn_i     (trstn_i),
		.start_i     (cpu_start),
		.op_i        (op),
		.wdata_i     (cmd_wdata),
		.cpu_bp_i    (cpu_bp_i),
		.cpu_stall_o (cpu_stall_o),
		.cpu_rst_o   (cpu_rst_o),
		.status_o    (cpu_status)
	);

	dbg_result_shift i_result_shift (
		.tck_i          (tck_i),
		.trstn_i        (trstn_i),
		.capture_dr_i   (capture_dr_i),
		.shift_dr_i     (shift_dr_i),
		.debug_select_i (debug_select_i),
		.module_i       (module_sel),
		.done_i         (bus_done),
		.rdata_i        (bus_rdata),
		.status_i       (cpu_status),
		.tdo_o          (tdo_o)
	);

endmodule

`default_nettype wire

// ==== verification/dbg_tb.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "dbg_macros.svh"

module dbg_tb
	import dbg_pkg::*;
();

	localparam logic [1:0] R_NONE = 2'd0;
	localparam logic [1:0] R_BUS = 2'd1;
	localparam logic [1:0] R_CPU = 2'd2;
	localparam logic [1:0] R_ZERO = 2'd3;

	// a command row holds the stimulus and then what the capture and the outputs must show.
	typedef struct packed {
		logic                            sel;
		dbg_module_e                     mod;
		dbg_op_e                         op;
		logic [`DBG_ADDR_WIDTH-1:0]      addr;
		logic [`DBG_DATA_WIDTH-1:0]      data;
		logic                            hold;
		logic [`DBG_NB_CORES-1:0]        bp;
		logic [1:0]                      rkind;
		logic [`DBG_DATA_WIDTH-1:0]      exp_word;
		logic [`DBG_STATUS_WIDTH-1:0]    exp_stat;
		logic [2*`DBG_NB_CORES-1:0]      exp_cpu; // {stall, rst}.
		logic                            exp_bus;
	} row_t;

	logic                            tck_i = 1'b0;
	logic                            trstn_i = 1'b0;
	logic                            tdi_i = 1'b0;
	logic                            tdo_o;
	logic                            shift_dr_i = 1'b0;
	logic                            update_dr_i = 1'b0;
	logic                            capture_dr_i = 1'b0;
	logic                            debug_select_i = 1'b1;
	logic                            bus_stb_o;
	logic                            bus_we_o;
	logic [`DBG_ADDR_WIDTH-1:0]      bus_addr_o;
	logic [`DBG_DATA_WIDTH-1:0]      bus_wdata_o;
	logic                            bus_ack_i = 1'b0;
	logic [`DBG_DATA_WIDTH-1:0]      bus_rdata_i = '0;
	logic [`DBG_NB_CORES-1:0]        cpu_bp_i = '0;
	logic [`DBG_NB_CORES-1:0]        cpu_stall_o;
	logic [`DBG_NB_CORES-1:0]        cpu_rst_o;

	logic [`DBG_DATA_WIDTH-1:0]      mem [256];
	logic [31:0]                     rng = 32'd25;
	logic                            hold_ack = 1'b0;
	logic                            in_req = 1'b0;
	logic [1:0]                      ack_wait = 2'd0;
	int                              req_count = 0;
	dbg_op_e                         req_op = OP_NOP;
	logic [`DBG_ADDR_WIDTH-1:0]      req_addr = '0;
	logic [`DBG_DATA_WIDTH-1:0]      req_wdata = '0;
	row_t                            rows[$];
	int                              errors = 0;
	int                              checks = 0;
	int                              passed = 0;
	int                              failed = 0;

	dbg_top uut (
		.tck_i          (tck_i),
		.trstn_i        (trstn_i),
		.tdi_i          (tdi_i),
		.tdo_o          (tdo_o),
		.shift_dr_i     (shift_dr_i),
		.update_dr_i    (update_dr_i),
		.capture_dr_i   (capture_dr_i),
		.debug_select_i (debug_select_i),
		.bus_stb_o      (bus_stb_o),
		.bus_we_o       (bus_we_o),
		.bus_addr_o     (bus_addr_o),
		.bus_wdata_o    (bus_wdata_o),
		.bus_ack_i      (bus_ack_i),
		.bus_rdata_i    (bus_rdata_i),
		.cpu_bp_i       (cpu_bp_i),
		.cpu_stall_o    (cpu_stall_o),
		.cpu_rst_o      (cpu_rst_o)
	);

	always #50 tck_i = ~tck_i;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic logic [31:0] fill_word(input logic [7:0] a);
		return {8'ha5, a, ~a, a ^ 8'h3c};
	endfunction

	// the memory model acks each request after 0 to 3 cycles unless held.
	always @(posedge tck_i) begin
		if (bus_ack_i) begin
			bus_ack_i <= 1'b0;
		end else if (bus_stb_o) begin
			if (!in_req) begin
				in_req = 1'b1;
				rng = xorshift32(rng);
				ack_wait = rng[1:0];
				req_count++;
				req_op = bus_we_o ? OP_BUS_WRITE : OP_BUS_READ;
				req_addr = bus_addr_o;
				req_wdata = bus_wdata_o;
			end
			if (ack_wait != 2'd0) begin
				ack_wait--;
			end else if (!hold_ack) begin
				bus_ack_i <= 1'b1;
				bus_rdata_i <= mem[req_addr[7:0]];
				if (req_op == OP_BUS_WRITE)
					mem[req_addr[7:0]] = req_wdata;
				in_req = 1'b0;
			end
		end
	end

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_status(input string name, input logic [`DBG_STATUS_WIDTH-1:0] got,
			input logic [`DBG_STATUS_WIDTH-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_op(input string name, input dbg_op_e got, input dbg_op_e exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t %s got %s expected %s", $time, name, got.name(), exp.name());
		end
	endtask

	task automatic add_row(input logic sel, input dbg_module_e mod, input dbg_op_e op,
			input logic [15:0] addr, input logic [31:0] data, input logic hold,
			input logic [1:0] bp, input logic [1:0] rkind, input logic [31:0] exp_word,
			input logic [5:0] exp_stat, input logic [3:0] exp_cpu, input logic exp_bus);
		row_t r;
		r = {sel, mod, op, addr, data, hold, bp, rkind, exp_word, exp_stat, exp_cpu, exp_bus};
		rows.push_back(r);
	endtask

	// runs capture, 64 shift cycles and update, and returns the captured result lsb first.
	task automatic shift_dr(input logic [63:0] dr, output logic [32:0] res);
		@(posedge tck_i);
		capture_dr_i <= 1'b1;
		@(posedge tck_i);
		capture_dr_i <= 1'b0;
		shift_dr_i <= 1'b1;
		tdi_i <= dr[0];
		for (int i = 0; i < 64; i++) begin
			@(negedge tck_i);
			if (i < 33)
				res[i] = tdo_o;
			@(posedge tck_i);
			if (i < 63)
				tdi_i <= dr[i+1];
		end
		shift_dr_i <= 1'b0;
		update_dr_i <= 1'b1;
		@(posedge tck_i);
		update_dr_i <= 1'b0;
	endtask

	task automatic apply_row(input int idx, input row_t r);
		logic [63:0] dr;
		logic [32:0] res;
		int start_cnt;
		int err0;
		int t;
		err0 = errors;
		start_cnt = req_count;
		hold_ack = r.hold;
		if (r.bp != '0) begin
			@(posedge tck_i);
			cpu_bp_i <= r.bp;
			@(posedge tck_i);
			cpu_bp_i <= '0;
		end
		if (r.sel)
			dr = {1'b1, r.mod, 58'd0};
		else
			dr = {1'b0, r.op, r.data, r.addr, 11'd0};
		shift_dr(dr, res);
		case (r.rkind)
			R_BUS: begin
				check_word("result rdata", res[32:1], r.exp_word);
				check_status("result done", {5'd0, res[0]}, r.exp_stat);
			end
			R_CPU: begin
				check_status("result status", res[6:1], r.exp_stat);
				check_word("result cpu tag", {5'd0, res[32:7], res[0]}, 32'd1);
			end
			R_ZERO: begin
				check_word("result high", res[32:1], 32'd0);
				check_status("result low", {5'd0, res[0]}, 6'd0);
			end
			default: ;
		endcase
		if (r.exp_bus) begin
			t = 0;
			while (req_count == start_cnt && t < 20) begin
				@(negedge tck_i);
				t++;
			end
			if (req_count == start_cnt) begin
				errors++;
				$display("TIMEOUT row %0d: no bus request within 20 cycles", idx);
			end else begin
				check_op("bus op", req_op, r.op);
				check_word("bus_addr_o", {16'd0, req_addr}, {16'd0, r.addr});
				if (r.op == OP_BUS_WRITE)
					check_word("bus_wdata_o", req_wdata, r.data);
				t = 0;
				while (bus_stb_o && !r.hold && t < 20) begin
					@(negedge tck_i);
					t++;
				end
				if (bus_stb_o && !r.hold) begin
					errors++;
					$display("TIMEOUT row %0d: bus strobe never dropped", idx);
				end
			end
		end
		repeat (4) @(negedge tck_i);
		check_word("bus requests", req_count, start_cnt + int'(r.exp_bus));
		check_status("cpu_stall_o/cpu_rst_o", {2'b00, cpu_stall_o, cpu_rst_o}, {2'b00, r.exp_cpu});
		if (errors == err0) begin
			passed++;
			$display("row %0d passed", idx);
		end else begin
			failed++;
			$display("row %0d failed", idx);
		end
	endtask

	initial begin
		for (int i = 0; i < 256; i++)
			mem[i] = fill_word(i[7:0]);
		repeat (5) @(posedge tck_i);
		trstn_i <= 1'b1;
		@(negedge tck_i);
		check_word("bus_stb_o", {31'd0, bus_stb_o}, 32'd0);
		check_word("tdo_o", {31'd0, tdo_o}, 32'd0);
		check_status("cpu_stall_o/cpu_rst_o", {2'b00, cpu_stall_o, cpu_rst_o}, 6'd0);
		if (errors == 0) begin
			passed++;
			$display("reset passed");
		end else begin
			failed++;
			$display("reset failed");
		end

		// bus write then read back.
		add_row(1'b1, MOD_BUS, OP_NOP, 16'h0000, 32'h0, 1'b0, 2'b00,
			R_BUS, 32'h0, 6'd0, 4'b0000, 1'b0);
		add_row(1'b0, MOD_BUS, OP_BUS_WRITE, 16'h0012, 32'hdead_beef, 1'b0, 2'b00,
			R_NONE, 32'h0, 6'd0, 4'b0000, 1'b1);
		add_row(1'b0, MOD_BUS, OP_BUS_READ, 16'h0012, 32'h0, 1'b0, 2'b00,
			R_BUS, 32'h0, 6'd1, 4'b0000, 1'b1);
		add_row(1'b0, MOD_BUS, OP_NOP, 16'h0000, 32'h0, 1'b0, 2'b00,
			R_BUS, 32'hdead_beef, 6'd1, 4'b0000, 1'b0);
		// cpu control and breakpoint.
		add_row(1'b1, MOD_CPU, OP_NOP, 16'h0000, 32'h0, 1'b0, 2'b00,
			R_BUS, 32'hdead_beef, 6'd1, 4'b0000, 1'b0);
		add_row(1'b0, MOD_BUS, OP_CPU_WRITE, 16'h0000, 32'h9, 1'b0, 2'b00,
			R_CPU, 32'h0, 6'b000000, 4'b0110, 1'b0);
		add_row(1'b0, MOD_BUS, OP_CPU_STATUS, 16'h0000, 32'h0, 1'b0, 2'b10,
			R_CPU, 32'h0, 6'b101110, 4'b1110, 1'b0);
		add_row(1'b0, MOD_BUS, OP_CPU_WRITE, 16'h0000, 32'h0, 1'b0, 2'b00,
			R_CPU, 32'h0, 6'b101110, 4'b0000, 1'b0);
		add_row(1'b0, MOD_BUS, OP_CPU_STATUS, 16'h0000, 32'h0, 1'b0, 2'b00,
			R_CPU, 32'h0, 6'b000000, 4'b0000, 1'b0);
		// busy inhibit with ack held back.
		add_row(1'b1, MOD_BUS, OP_NOP, 16'h0000, 32'h0, 1'b0, 2'b00,
			R_CPU, 32'h0, 6'b000000, 4'b0000, 1'b0);
		add_row(1'b0, MOD_BUS, OP_BUS_WRITE, 16'h0034, 32'h1234_5678, 1'b1, 2'b00,
			R_BUS, 32'hdead_beef, 6'd1, 4'b0000, 1'b1);
		add_row(1'b0, MOD_BUS, OP_BUS_WRITE, 16'h0056, 32'hcafe_f00d, 1'b1, 2'b00,
			R_BUS, 32'hdead_beef, 6'd0, 4'b0000, 1'b0);
		add_row(1'b1, MOD_CPU, OP_NOP, 16'h0000, 32'h0, 1'b1, 2'b00,
			R_BUS, 32'hdead_beef, 6'd0, 4'b0000, 1'b0);
		add_row(1'b0, MOD_BUS, OP_BUS_READ, 16'h0056, 32'h0, 1'b0, 2'b00,
			R_NONE, 32'h0, 6'd0, 4'b0000, 1'b1);
		add_row(1'b0, MOD_BUS, OP_NOP, 16'h0000, 32'h0, 1'b0, 2'b00,
			R_BUS, fill_word(8'h56), 6'd1, 4'b0000, 1'b0);
		add_row(1'b0, MOD_BUS, OP_BUS_READ, 16'h0034, 32'h0, 1'b0, 2'b00,
			R_BUS, fill_word(8'h56), 6'd1, 4'b0000, 1'b1);
		add_row(1'b0, MOD_BUS, OP_NOP, 16'h0000, 32'h0, 1'b0, 2'b00,
			R_BUS, 32'h1234_5678, 6'd1, 4'b0000, 1'b0);
		// unmapped module id.
		add_row(1'b1, dbg_module_e'(5'd5), OP_NOP, 16'h0000, 32'h0, 1'b0, 2'b00,
			R_BUS, 32'h1234_5678, 6'd1, 4'b0000, 1'b0);
		add_row(1'b0, MOD_BUS, OP_BUS_WRITE, 16'h0078, 32'h0bad_f00d, 1'b0, 2'b00,
			R_ZERO, 32'h0, 6'd0, 4'b0000, 1'b0);
		add_row(1'b0, MOD_BUS, OP_CPU_WRITE, 16'h0000, 32'hf, 1'b0, 2'b00,
			R_ZERO, 32'h0, 6'd0, 4'b0000, 1'b0);

		for (int i = 0; i < rows.size(); i++)
			apply_row(i, rows[i]);

		$display("tests passed %0d, failed %0d, checks %0d, errors %0d",
			passed, failed, checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
